// File: source/lc4_isa_pkg.sv
/* lc4 isa package
   word widths, opcode and sub-op encodings, nzp codes and the instruction-word union */
package lc4_isa_pkg;

    // datapath and register select widths
    localparam int word_w = 16;
    localparam int rsel_w = 3;
    localparam int nzp_w  = 3;

    // one-hot condition codes, n z p from msb down
    localparam logic [nzp_w-1:0] nzp_n = 3'b100;
    localparam logic [nzp_w-1:0] nzp_z = 3'b010;
    localparam logic [nzp_w-1:0] nzp_p = 3'b001;

    // first fetch address after reset
    localparam logic [word_w-1:0] reset_pc = 16'h8200;

    // kept opcodes
    localparam logic [3:0] op_br    = 4'b0000;
    localparam logic [3:0] op_arith = 4'b0001;
    localparam logic [3:0] op_logic = 4'b0101;
    localparam logic [3:0] op_ldr   = 4'b0110;
    localparam logic [3:0] op_str   = 4'b0111;
    localparam logic [3:0] op_const = 4'b1001;

    // arithmetic sub-ops in bits 5:3, bit 5 clear
    localparam logic [2:0] sub_add = 3'b000;
    localparam logic [2:0] sub_mul = 3'b001;
    localparam logic [2:0] sub_sub = 3'b010;
    // logic sub-ops, same field
    localparam logic [2:0] sub_and = 3'b000;
    localparam logic [2:0] sub_or  = 3'b010;
    localparam logic [2:0] sub_xor = 3'b011;

    // one instruction word seen three ways
    typedef union packed {
        // register form, also holds the sub-op
        struct packed {
            logic [3:0]        opcode;
            logic [rsel_w-1:0] rd;
            logic [rsel_w-1:0] rs;
            logic [2:0]        subop;
            logic [rsel_w-1:0] rt;
        } rr;
        // immediate form, bit 5 set selects imm5 for arith and logic
        struct packed {
            logic [3:0]        opcode;
            logic [rsel_w-1:0] rd;
            logic [rsel_w-1:0] rs;
            logic [5:0]        imm6;
        } ri;
        // branch and const form, rd_nzp is nzp mask for br
        struct packed {
            logic [3:0]        opcode;
            logic [rsel_w-1:0] rd_nzp;
            logic [8:0]        imm9;
        } bc;
    } lc4_insn_u;

endpackage

// File: source/lc4_pipe_pkg.sv
/* lc4 pipeline package
   stall codes on the writeback trace, bypass selects and the bubble word */
package lc4_pipe_pkg;

    // stall code carried with every slot
    localparam logic [1:0] stall_none  = 2'd0;
    // flushed by a taken branch, also the empty slots after reset
    localparam logic [1:0] stall_flush = 2'd2;
    // bubble inserted behind a load
    localparam logic [1:0] stall_load  = 2'd3;

    // operand bypass selects
    localparam logic [1:0] fwd_reg = 2'd0;
    localparam logic [1:0] fwd_m   = 2'd1;
    localparam logic [1:0] fwd_w   = 2'd2;

    // all-zero word decodes as br with empty mask, a nop
    localparam logic [15:0] bubble_insn = 16'h0000;

    // packed control bundle width: three selects plus seven flags
    localparam int ctrl_w = 16;

endpackage

// File: source/lc4_ctrl_if.sv
`timescale 1ns/1ps
/* lc4 control bundle of one pipeline stage */
interface lc4_ctrl_if;
    logic [lc4_isa_pkg::rsel_w-1:0] rs;
    logic [lc4_isa_pkg::rsel_w-1:0] rt;
    logic [lc4_isa_pkg::rsel_w-1:0] rd;
    logic                           rs_re;
    logic                           rt_re;
    logic                           rd_we;
    logic                           nzp_we;
    logic                           is_load;
    logic                           is_store;
    logic                           is_branch;

    // decoder or stage register side
    modport producer (output rs, rt, rd, rs_re, rt_re, rd_we, nzp_we,
                      is_load, is_store, is_branch);
    // hazard unit and datapath side
    modport consumer (input rs, rt, rd, rs_re, rt_re, rd_we, nzp_we,
                      is_load, is_store, is_branch);
endinterface

// File: source/lc4_decoder.sv
`timescale 1ns/1ps
/* lc4 decoder
   turns one instruction word into register selects and control flags */
module lc4_decoder (
    input  lc4_isa_pkg::lc4_insn_u i_insn,
    lc4_ctrl_if.producer           ctrl
);

    always_comb begin
        // selects straight from the register form
        ctrl.rs        = i_insn.rr.rs;
        ctrl.rt        = i_insn.rr.rt;
        ctrl.rd        = i_insn.rr.rd;
        // anything not matched below is a nop
        ctrl.rs_re     = 1'b0;
        ctrl.rt_re     = 1'b0;
        ctrl.rd_we     = 1'b0;
        ctrl.nzp_we    = 1'b0;
        ctrl.is_load   = 1'b0;
        ctrl.is_store  = 1'b0;
        ctrl.is_branch = 1'b0;
        case (i_insn.rr.opcode)
            lc4_isa_pkg::op_arith: begin
                // add immediate reads rs only
                if (i_insn.ri.imm6[5]) begin
                    ctrl.rs_re  = 1'b1;
                    ctrl.rd_we  = 1'b1;
                    ctrl.nzp_we = 1'b1;
                end else if (i_insn.rr.subop inside {lc4_isa_pkg::sub_add,
                        lc4_isa_pkg::sub_mul, lc4_isa_pkg::sub_sub}) begin
                    ctrl.rs_re  = 1'b1;
                    ctrl.rt_re  = 1'b1;
                    ctrl.rd_we  = 1'b1;
                    ctrl.nzp_we = 1'b1;
                end
            end
            lc4_isa_pkg::op_logic: begin
                // and immediate
                if (i_insn.ri.imm6[5]) begin
                    ctrl.rs_re  = 1'b1;
                    ctrl.rd_we  = 1'b1;
                    ctrl.nzp_we = 1'b1;
                end else if (i_insn.rr.subop inside {lc4_isa_pkg::sub_and,
                        lc4_isa_pkg::sub_or, lc4_isa_pkg::sub_xor}) begin
                    ctrl.rs_re  = 1'b1;
                    ctrl.rt_re  = 1'b1;
                    ctrl.rd_we  = 1'b1;
                    ctrl.nzp_we = 1'b1;
                end
            end
            lc4_isa_pkg::op_ldr: begin
                ctrl.rs_re   = 1'b1;
                ctrl.rd_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.is_load = 1'b1;
            end
            lc4_isa_pkg::op_str: begin
                // store data register sits in the rd field
                ctrl.rt       = i_insn.ri.rd;
                ctrl.rs_re    = 1'b1;
                ctrl.rt_re    = 1'b1;
                ctrl.is_store = 1'b1;
            end
            lc4_isa_pkg::op_const: begin
                ctrl.rd_we  = 1'b1;
                ctrl.nzp_we = 1'b1;
            end
            // empty mask is the nop, not a branch
            lc4_isa_pkg::op_br: ctrl.is_branch = |i_insn.bc.rd_nzp;
            default: ;
        endcase
    end

endmodule

// File: source/lc4_regfile.sv
`timescale 1ns/1ps
/* lc4 register file
   eight registers, one write port, two read ports with write-before-read */
module lc4_regfile (
    input  logic                             gwe,
    input  logic                             i_arst_n,
    input  logic [lc4_isa_pkg::rsel_w-1:0]   i_rs,
    input  logic [lc4_isa_pkg::rsel_w-1:0]   i_rt,
    input  logic [lc4_isa_pkg::rsel_w-1:0]   i_rd,
    input  logic                             i_we,
    input  logic [lc4_isa_pkg::word_w-1:0]   i_wdata,
    output logic [lc4_isa_pkg::word_w-1:0]   o_rs_data,
    output logic [lc4_isa_pkg::word_w-1:0]   o_rt_data
);

    logic [lc4_isa_pkg::word_w-1:0] regs [2**lc4_isa_pkg::rsel_w];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            // registers start at zero
            for (int i = 0; i < 2**lc4_isa_pkg::rsel_w; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // value being written this cycle reaches decode directly
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: source/lc4_alu.sv
`timescale 1ns/1ps
/* lc4 execute unit
   arithmetic, logic, const, memory address and branch target */
module lc4_alu (
    input  lc4_isa_pkg::lc4_insn_u          i_insn,
    input  logic [lc4_isa_pkg::word_w-1:0]  i_pc,
    input  logic [lc4_isa_pkg::word_w-1:0]  i_rs_data,
    input  logic [lc4_isa_pkg::word_w-1:0]  i_rt_data,
    output logic [lc4_isa_pkg::word_w-1:0]  o_result
);

    logic [lc4_isa_pkg::word_w-1:0] imm5_x;
    logic [lc4_isa_pkg::word_w-1:0] imm6_x;
    logic [lc4_isa_pkg::word_w-1:0] imm9_x;

    // sign-extended immediates
    assign imm5_x = {{(lc4_isa_pkg::word_w-5){i_insn.ri.imm6[4]}}, i_insn.ri.imm6[4:0]};
    assign imm6_x = {{(lc4_isa_pkg::word_w-6){i_insn.ri.imm6[5]}}, i_insn.ri.imm6};
    assign imm9_x = {{(lc4_isa_pkg::word_w-9){i_insn.bc.imm9[8]}}, i_insn.bc.imm9};

    always_comb begin
        o_result = '0;
        case (i_insn.rr.opcode)
            lc4_isa_pkg::op_arith: begin
                if (i_insn.ri.imm6[5]) begin
                    o_result = i_rs_data + imm5_x;
                end else begin
                    case (i_insn.rr.subop)
                        lc4_isa_pkg::sub_add: o_result = i_rs_data + i_rt_data;
                        lc4_isa_pkg::sub_mul: o_result = i_rs_data * i_rt_data;
                        lc4_isa_pkg::sub_sub: o_result = i_rs_data - i_rt_data;
                        default: ;
                    endcase
                end
            end
            lc4_isa_pkg::op_logic: begin
                if (i_insn.ri.imm6[5]) begin
                    o_result = i_rs_data & imm5_x;
                end else begin
                    case (i_insn.rr.subop)
                        lc4_isa_pkg::sub_and: o_result = i_rs_data & i_rt_data;
                        lc4_isa_pkg::sub_or:  o_result = i_rs_data | i_rt_data;
                        lc4_isa_pkg::sub_xor: o_result = i_rs_data ^ i_rt_data;
                        default: ;
                    endcase
                end
            end
            lc4_isa_pkg::op_const: o_result = imm9_x;
            // base plus offset for both memory ops
            lc4_isa_pkg::op_ldr,
            lc4_isa_pkg::op_str:   o_result = i_rs_data + imm6_x;
            // pc-relative target, used only when taken
            lc4_isa_pkg::op_br:    o_result = i_pc + 1'b1 + imm9_x;
            default: ;
        endcase
    end

endmodule

// File: source/lc4_hazard_unit.sv
`timescale 1ns/1ps
/* lc4 hazard unit
   load-use and load-branch stalls, branch flush, operand and store-data bypass selects */
module lc4_hazard_unit (
    lc4_ctrl_if.consumer d_ctrl,
    lc4_ctrl_if.consumer x_ctrl,
    lc4_ctrl_if.consumer m_ctrl,
    lc4_ctrl_if.consumer w_ctrl,
    output logic         o_stall,
    output logic [1:0]   o_fwd_rs,
    output logic [1:0]   o_fwd_rt,
    output logic         o_fwd_store,
    input  logic         i_x_branch_taken,
    output logic         o_flush
);

    logic ld_use;
    logic ld_br;

    // store data from a load is served by the wm path, so only its address stalls
    assign ld_use = x_ctrl.is_load &&
                    ((d_ctrl.rs_re && d_ctrl.rs == x_ctrl.rd) ||
                     (d_ctrl.rt_re && !d_ctrl.is_store && d_ctrl.rt == x_ctrl.rd));
    // branch needs load nzp, which is known only at writeback
    assign ld_br  = x_ctrl.is_load && d_ctrl.is_branch;
    assign o_stall = ld_use || ld_br;

    // memory stage wins over writeback, the younger value
    always_comb begin
        o_fwd_rs = lc4_pipe_pkg::fwd_reg;
        if (x_ctrl.rs_re && m_ctrl.rd_we && m_ctrl.rd == x_ctrl.rs) begin
            o_fwd_rs = lc4_pipe_pkg::fwd_m;
        end else if (x_ctrl.rs_re && w_ctrl.rd_we && w_ctrl.rd == x_ctrl.rs) begin
            o_fwd_rs = lc4_pipe_pkg::fwd_w;
        end
    end

    always_comb begin
        o_fwd_rt = lc4_pipe_pkg::fwd_reg;
        if (x_ctrl.rt_re && m_ctrl.rd_we && m_ctrl.rd == x_ctrl.rt) begin
            o_fwd_rt = lc4_pipe_pkg::fwd_m;
        end else if (x_ctrl.rt_re && w_ctrl.rd_we && w_ctrl.rd == x_ctrl.rt) begin
            o_fwd_rt = lc4_pipe_pkg::fwd_w;
        end
    end

    // wm bypass, store in memory takes data being written back
    assign o_fwd_store = m_ctrl.is_store && w_ctrl.rd_we && w_ctrl.rd == m_ctrl.rt;

    // taken branch kills decode and execute slots
    assign o_flush = i_x_branch_taken;

endmodule

// File: source/lc4_core.sv
`timescale 1ns/1ps
/* lc4 core: five-stage single-issue pipeline, fetch to writeback
   pc, stage registers, nzp flags, bypass muxes and the writeback trace */
module lc4_core (
    input  logic                             gwe,
    input  logic                             i_arst_n,
    output logic [lc4_isa_pkg::word_w-1:0]   o_pc,
    input  logic [lc4_isa_pkg::word_w-1:0]   i_insn,
    output logic [lc4_isa_pkg::word_w-1:0]   o_dmem_addr,
    input  logic [lc4_isa_pkg::word_w-1:0]   i_dmem_rdata,
    output logic                             o_dmem_we,
    output logic [lc4_isa_pkg::word_w-1:0]   o_dmem_wdata,
    output logic [lc4_isa_pkg::word_w-1:0]   o_wb_pc,
    output logic [lc4_isa_pkg::word_w-1:0]   o_wb_insn,
    output logic [1:0]                       o_wb_stall,
    output logic                             o_wb_rf_we,
    output logic [lc4_isa_pkg::rsel_w-1:0]   o_wb_rf_wsel,
    output logic [lc4_isa_pkg::word_w-1:0]   o_wb_rf_data,
    output logic                             o_wb_nzp_we,
    output logic [lc4_isa_pkg::nzp_w-1:0]    o_wb_nzp
);

    lc4_ctrl_if d_ctrl ();
    lc4_ctrl_if x_ctrl ();
    lc4_ctrl_if m_ctrl ();
    lc4_ctrl_if w_ctrl ();

    logic [lc4_isa_pkg::word_w-1:0] pc, d_pc, x_pc, m_pc, w_pc;
    lc4_isa_pkg::lc4_insn_u         d_insn, x_insn, m_insn, w_insn;
    logic [1:0]                     d_stall, x_stall, m_stall, w_stall;
    logic [lc4_pipe_pkg::ctrl_w-1:0] d_cbits, x_cbits, m_cbits, w_cbits;
    logic [lc4_isa_pkg::word_w-1:0] rf_rs_data, rf_rt_data, x_rs_data, x_rt_data;
    logic [lc4_isa_pkg::word_w-1:0] x_rs_val, x_rt_val, alu_result;
    logic [lc4_isa_pkg::word_w-1:0] m_result, m_rt_data, w_result, w_rdata, wb_data;
    logic [lc4_isa_pkg::nzp_w-1:0]  nzp_reg, x_nzp;
    logic [1:0]                     fwd_rs, fwd_rt;
    logic                           stall, flush, fwd_store, x_taken;

    // condition code of a written value
    function automatic logic [lc4_isa_pkg::nzp_w-1:0] nzp_of(
        input logic [lc4_isa_pkg::word_w-1:0] v);
        if (v[lc4_isa_pkg::word_w-1]) return lc4_isa_pkg::nzp_n;
        if (v == '0) return lc4_isa_pkg::nzp_z;
        return lc4_isa_pkg::nzp_p;
    endfunction

    lc4_decoder     decoder_i (.i_insn(d_insn), .ctrl(d_ctrl));

    lc4_regfile regfile_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt), .i_rd(w_ctrl.rd),
        .i_we(w_ctrl.rd_we), .i_wdata(wb_data),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

    lc4_alu alu_i (
        .i_insn(x_insn), .i_pc(x_pc), .i_rs_data(x_rs_val), .i_rt_data(x_rt_val),
        .o_result(alu_result)
    );

    lc4_hazard_unit hazard_i (
        .d_ctrl(d_ctrl), .x_ctrl(x_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
        .o_stall(stall), .o_fwd_rs(fwd_rs), .o_fwd_rt(fwd_rt), .o_fwd_store(fwd_store),
        .i_x_branch_taken(x_taken), .o_flush(flush)
    );

    // control bundles travel down the pipe as flat words
    assign d_cbits = {d_ctrl.rs, d_ctrl.rt, d_ctrl.rd, d_ctrl.rs_re, d_ctrl.rt_re,
                      d_ctrl.rd_we, d_ctrl.nzp_we, d_ctrl.is_load, d_ctrl.is_store,
                      d_ctrl.is_branch};
    assign {x_ctrl.rs, x_ctrl.rt, x_ctrl.rd, x_ctrl.rs_re, x_ctrl.rt_re, x_ctrl.rd_we,
            x_ctrl.nzp_we, x_ctrl.is_load, x_ctrl.is_store, x_ctrl.is_branch} = x_cbits;
    assign {m_ctrl.rs, m_ctrl.rt, m_ctrl.rd, m_ctrl.rs_re, m_ctrl.rt_re, m_ctrl.rd_we,
            m_ctrl.nzp_we, m_ctrl.is_load, m_ctrl.is_store, m_ctrl.is_branch} = m_cbits;
    assign {w_ctrl.rs, w_ctrl.rt, w_ctrl.rd, w_ctrl.rs_re, w_ctrl.rt_re, w_ctrl.rd_we,
            w_ctrl.nzp_we, w_ctrl.is_load, w_ctrl.is_store, w_ctrl.is_branch} = w_cbits;

    // fetch into decode, pc holds on stall and redirects on flush
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= lc4_isa_pkg::reset_pc;
            d_insn  <= lc4_pipe_pkg::bubble_insn;
            d_stall <= lc4_pipe_pkg::stall_flush;
        end else if (flush) begin
            pc      <= alu_result;
            d_insn  <= lc4_pipe_pkg::bubble_insn;
            d_stall <= lc4_pipe_pkg::stall_flush;
        end else if (!stall) begin
            pc      <= pc + 1'b1;
            d_insn  <= i_insn;
            d_stall <= lc4_pipe_pkg::stall_none;
        end
    end

    // decode into execute, bubble on stall or flush
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_insn  <= lc4_pipe_pkg::bubble_insn;
            x_cbits <= '0;
            x_stall <= lc4_pipe_pkg::stall_flush;
        end else if (flush || stall) begin
            x_insn  <= lc4_pipe_pkg::bubble_insn;
            x_cbits <= '0;
            x_stall <= flush ? lc4_pipe_pkg::stall_flush : lc4_pipe_pkg::stall_load;
        end else begin
            x_insn  <= d_insn;
            x_cbits <= d_cbits;
            x_stall <= d_stall;
        end
    end

    // execute to memory to writeback, never held
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_insn  <= lc4_pipe_pkg::bubble_insn;
            m_cbits <= '0;
            m_stall <= lc4_pipe_pkg::stall_flush;
            w_insn  <= lc4_pipe_pkg::bubble_insn;
            w_cbits <= '0;
            w_stall <= lc4_pipe_pkg::stall_flush;
        end else begin
            m_insn  <= x_insn;
            m_cbits <= x_cbits;
            m_stall <= x_stall;
            w_insn  <= m_insn;
            w_cbits <= m_cbits;
            w_stall <= m_stall;
        end
    end

    // payload, only meaningful alongside valid control
    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_pc <= pc;
        end
        x_pc      <= d_pc;
        x_rs_data <= rf_rs_data;
        x_rt_data <= rf_rt_data;
        m_pc      <= x_pc;
        m_result  <= alu_result;
        m_rt_data <= x_rt_val;
        w_pc      <= m_pc;
        w_result  <= m_result;
        w_rdata   <= i_dmem_rdata;
    end

    // nzp written at writeback
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_reg <= '0;
        end else if (w_ctrl.nzp_we) begin
            nzp_reg <= nzp_of(wb_data);
        end
    end

    assign wb_data = w_ctrl.is_load ? w_rdata : w_result;

    // mx and wx bypass of execute operands
    assign x_rs_val = (fwd_rs == lc4_pipe_pkg::fwd_m) ? m_result :
                      (fwd_rs == lc4_pipe_pkg::fwd_w) ? wb_data : x_rs_data;
    assign x_rt_val = (fwd_rt == lc4_pipe_pkg::fwd_m) ? m_result :
                      (fwd_rt == lc4_pipe_pkg::fwd_w) ? wb_data : x_rt_data;

    // branch condition sees the youngest nzp writer first
    assign x_nzp   = m_ctrl.nzp_we ? nzp_of(m_result) :
                     w_ctrl.nzp_we ? nzp_of(wb_data) : nzp_reg;
    assign x_taken = x_ctrl.is_branch && |(x_insn.bc.rd_nzp & x_nzp);

    // data memory, store data may come over the wm path
    assign o_pc         = pc;
    assign o_dmem_addr  = m_result;
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_wdata = fwd_store ? wb_data : m_rt_data;

    // writeback trace
    assign o_wb_pc      = w_pc;
    assign o_wb_insn    = w_insn;
    assign o_wb_stall   = w_stall;
    assign o_wb_rf_we   = w_ctrl.rd_we;
    assign o_wb_rf_wsel = w_ctrl.rd;
    assign o_wb_rf_data = wb_data;
    assign o_wb_nzp_we  = w_ctrl.nzp_we;
    assign o_wb_nzp     = nzp_of(wb_data);

endmodule

// File: dv/lc4_tb_clock.sv
`timescale 1ns/1ps
/* lc4 testbench clock and reset
   100 ns clock, reset held low for 16 cycles */
module lc4_tb_clock (
    output logic o_gwe,
    output logic o_arst_n
);

    initial begin
        o_gwe    = 1'b0;
        o_arst_n = 1'b0;
        repeat (16) @(posedge o_gwe);
        // release a quarter period after the edge, away from both clock edges
        #25;
        o_arst_n = 1'b1;
    end

    always #50 o_gwe = ~o_gwe;

endmodule

// File: dv/lc4_isa_model.svh
/* lc4 instruction-level model
   random forward-branching program and in-order execution giving the expected trace */
`ifndef LC4_ISA_MODEL_SVH
`define LC4_ISA_MODEL_SVH

localparam int prog_len = 200;

// one retired instruction, pre is the bubble code expected just before it
typedef struct packed {
    logic [15:0] pc;
    logic [15:0] insn;
    logic        rf_we;
    logic [2:0]  wsel;
    logic [15:0] data;
    logic        nzp_we;
    logic [2:0]  nzp;
    logic [1:0]  pre;
} retire_t;

logic [15:0] prog [prog_len];
logic [15:0] mdl_regs [8];
logic [15:0] mdl_dmem [logic [15:0]];
retire_t     exp_trace [$];
logic [15:0] st_addr [$];
logic [15:0] st_data [$];

// data memory contents before any store
function automatic logic [15:0] fill_word(input logic [15:0] a);
    return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
endfunction

function automatic logic [2:0] cond_code(input logic [15:0] v);
    if (v[15]) return 3'b100;
    if (v == 16'h0000) return 3'b010;
    return 3'b001;
endfunction

task automatic gen_program();
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    int kind;
    int sel;
    int max_off;
    for (int i = 0; i < prog_len - 2; i++) begin
        rd   = 3'($urandom_range(0, 7));
        rs   = 3'($urandom_range(0, 7));
        rt   = 3'($urandom_range(0, 7));
        kind = $urandom_range(0, 9);
        sel  = $urandom_range(0, 2);
        // forward only, and never past the closing const
        max_off = (197 - i > 15) ? 15 : 197 - i;
        // store of the loaded register right behind its load, other base
        // so no stall and the data takes the wm path
        if (i > 0 && prog[i-1][15:12] == lc4_isa_pkg::op_ldr && kind inside {6, 7}) begin
            kind = 7;
            rd   = prog[i-1][11:9];
            rs   = rd + 3'd1;
        end
        case (kind)
            0: prog[i] = {lc4_isa_pkg::op_arith, rd, rs, 3'(sel), rt};
            1: prog[i] = {lc4_isa_pkg::op_arith, rd, rs, 1'b1, 5'($urandom)};
            2: prog[i] = {lc4_isa_pkg::op_logic, rd, rs,
                          (sel == 0) ? 3'b000 : (sel == 1) ? 3'b010 : 3'b011, rt};
            3: prog[i] = {lc4_isa_pkg::op_logic, rd, rs, 1'b1, 5'($urandom)};
            4: prog[i] = {lc4_isa_pkg::op_const, rd, 9'($urandom)};
            5, 6: prog[i] = {lc4_isa_pkg::op_ldr, rd, rs, 6'($urandom)};
            7: prog[i] = {lc4_isa_pkg::op_str, rd, rs, 6'($urandom)};
            // mask may be empty, then it is a nop
            default: prog[i] = {lc4_isa_pkg::op_br, rd, 9'($urandom_range(0, max_off))};
        endcase
    end
    // const makes nzp nonzero so the closing self loop is taken
    prog[prog_len-2] = {lc4_isa_pkg::op_const, 3'd0, 9'd1};
    prog[prog_len-1] = {lc4_isa_pkg::op_br, 3'b111, 9'h1ff};
endtask

task automatic run_model();
    retire_t     e;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [2:0]  nzp;
    logic [2:0]  rd;
    logic [2:0]  prev_rd;
    logic        we;
    logic        rd_rs;
    logic        rd_rt;
    logic        is_ld;
    logic        taken;
    logic        prev_load;
    logic        prev_taken;
    logic        done;
    int          idx;
    idx = 0;
    nzp = 3'b000;
    prev_rd = 3'd0;
    prev_load = 1'b0;
    prev_taken = 1'b0;
    done = 1'b0;
    for (int r = 0; r < 8; r++) begin
        mdl_regs[r] = 16'h0000;
    end
    for (int n = 0; n < prog_len && !done; n++) begin
        w = prog[idx];
        rd = w[11:9];
        a = mdl_regs[w[8:6]];
        b = mdl_regs[w[2:0]];
        we = 1'b0;
        rd_rs = 1'b0;
        rd_rt = 1'b0;
        is_ld = 1'b0;
        taken = 1'b0;
        res = 16'h0000;
        case (w[15:12])
            lc4_isa_pkg::op_arith, lc4_isa_pkg::op_logic: begin
                we = 1'b1;
                rd_rs = 1'b1;
                rd_rt = !w[5];
                if (w[5] && w[15:12] == lc4_isa_pkg::op_arith) res = a + {{11{w[4]}}, w[4:0]};
                else if (w[5]) res = a & {{11{w[4]}}, w[4:0]};
                else if (w[15:12] == lc4_isa_pkg::op_arith)
                    res = (w[5:3] == 3'b000) ? a + b : (w[5:3] == 3'b001) ? a * b : a - b;
                else
                    res = (w[5:3] == 3'b000) ? a & b : (w[5:3] == 3'b010) ? a | b : a ^ b;
            end
            lc4_isa_pkg::op_ldr: begin
                we = 1'b1;
                rd_rs = 1'b1;
                is_ld = 1'b1;
                addr = a + {{10{w[5]}}, w[5:0]};
                res = mdl_dmem.exists(addr) ? mdl_dmem[addr] : fill_word(addr);
            end
            lc4_isa_pkg::op_str: begin
                // store data comes over the bypass, only the address can stall
                rd_rs = 1'b1;
                addr = a + {{10{w[5]}}, w[5:0]};
                mdl_dmem[addr] = mdl_regs[rd];
                st_addr.push_back(addr);
                st_data.push_back(mdl_regs[rd]);
            end
            lc4_isa_pkg::op_const: begin
                we = 1'b1;
                res = {{7{w[8]}}, w[8:0]};
            end
            default: taken = |(rd & nzp);
        endcase
        e.pc = lc4_isa_pkg::reset_pc + 16'(idx);
        e.insn = w;
        e.rf_we = we;
        e.wsel = rd;
        e.data = res;
        e.nzp_we = we;
        e.nzp = cond_code(res);
        if (prev_taken) e.pre = lc4_pipe_pkg::stall_flush;
        else if (prev_load && ((rd_rs && w[8:6] == prev_rd) || (rd_rt && w[2:0] == prev_rd) ||
                 (w[15:12] == lc4_isa_pkg::op_br && rd != 3'b000)))
            e.pre = lc4_pipe_pkg::stall_load;
        else e.pre = lc4_pipe_pkg::stall_none;
        exp_trace.push_back(e);
        if (we) begin
            mdl_regs[rd] = res;
            nzp = cond_code(res);
        end
        prev_load = is_ld;
        prev_rd = rd;
        prev_taken = taken;
        if (idx == prog_len - 1) done = 1'b1;
        else idx = taken ? idx + 1 + int'(w[8:0]) : idx + 1;
    end
endtask

`endif

// File: dv/lc4_core_tb.sv
`timescale 1ns/1ps
/* lc4 core testbench
   random program against the instruction model, retire trace and store checks */
module lc4_core_tb;

    logic        gwe;
    logic        arst_n;
    logic [15:0] o_pc;
    logic [15:0] i_insn;
    logic [15:0] o_dmem_addr;
    logic [15:0] i_dmem_rdata;
    logic        o_dmem_we;
    logic [15:0] o_dmem_wdata;
    logic [15:0] o_wb_pc;
    logic [15:0] o_wb_insn;
    logic [1:0]  o_wb_stall;
    logic        o_wb_rf_we;
    logic [2:0]  o_wb_rf_wsel;
    logic [15:0] o_wb_rf_data;
    logic        o_wb_nzp_we;
    logic [2:0]  o_wb_nzp;

    logic [15:0] tb_dmem [logic [15:0]];
    int          mismatches;
    int          others;
    int          nbub;
    logic [1:0]  bub_or;
    logic        first_retire;
    logic        done;

    `include "lc4_isa_model.svh"

    lc4_tb_clock clock_i (.o_gwe(gwe), .o_arst_n(arst_n));

    lc4_core lc4_core_i (
        .gwe(gwe), .i_arst_n(arst_n), .o_pc(o_pc), .i_insn(i_insn),
        .o_dmem_addr(o_dmem_addr), .i_dmem_rdata(i_dmem_rdata), .o_dmem_we(o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
        .o_wb_stall(o_wb_stall), .o_wb_rf_we(o_wb_rf_we), .o_wb_rf_wsel(o_wb_rf_wsel),
        .o_wb_rf_data(o_wb_rf_data), .o_wb_nzp_we(o_wb_nzp_we), .o_wb_nzp(o_wb_nzp)
    );

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // combinational memories, refreshed on the falling edge
    task automatic drive_memories();
        if (o_pc >= lc4_isa_pkg::reset_pc && o_pc < lc4_isa_pkg::reset_pc + 16'(prog_len))
            i_insn = prog[int'(o_pc - lc4_isa_pkg::reset_pc)];
        else i_insn = 16'h0000;
        i_dmem_rdata = tb_dmem.exists(o_dmem_addr) ? tb_dmem[o_dmem_addr] : fill_word(o_dmem_addr);
    endtask

    task automatic check_retire();
        retire_t e;
        if (exp_trace.size() == 0) begin
            $display("Instruction retired at pc %h after the model trace ended", o_wb_pc);
            others++;
            done = 1'b1;
            return;
        end
        e = exp_trace.pop_front();
        compare("wb pc", e.pc, o_wb_pc);
        compare("wb insn", e.insn, o_wb_insn);
        compare("wb rf we", 16'(e.rf_we), 16'(o_wb_rf_we));
        if (e.rf_we) begin
            compare("wb rf wsel", 16'(e.wsel), 16'(o_wb_rf_wsel));
            compare("wb rf data", e.data, o_wb_rf_data);
        end
        compare("wb nzp we", 16'(e.nzp_we), 16'(o_wb_nzp_we));
        if (e.nzp_we) compare("wb nzp", 16'(e.nzp), 16'(o_wb_nzp));
        // reset bubbles ahead of the first instruction are not counted
        if (!first_retire) begin
            compare("bubbles before insn", (e.pre == lc4_pipe_pkg::stall_none) ? 16'd0 :
                    (e.pre == lc4_pipe_pkg::stall_load) ? 16'd1 : 16'd2, 16'(nbub));
            compare("bubble stall code", 16'(e.pre), 16'(bub_or));
        end
        first_retire = 1'b0;
        nbub = 0;
        bub_or = 2'b00;
        if (exp_trace.size() == 0) done = 1'b1;
    endtask

    initial begin
        i_insn = 16'h0000;
        i_dmem_rdata = 16'h0000;
        mismatches = 0;
        others = 0;
        nbub = 0;
        bub_or = 2'b00;
        first_retire = 1'b1;
        done = 1'b0;
        void'($urandom(36290));
        gen_program();
        run_model();

        // outputs stay quiet through reset
        for (int cyc = 0; cyc < 40 && !arst_n; cyc++) begin
            @(negedge gwe);
            if (!arst_n) begin
                compare("reset dmem we", 16'h0000, 16'(o_dmem_we));
                compare("reset rf we", 16'h0000, 16'(o_wb_rf_we));
                compare("reset nzp we", 16'h0000, 16'(o_wb_nzp_we));
            end
            drive_memories();
        end
        if (!arst_n) begin
            $display("Reset was never released");
            others++;
        end
        compare("release pc", lc4_isa_pkg::reset_pc, o_pc);
        compare("release dmem we", 16'h0000, 16'(o_dmem_we));
        compare("release rf we", 16'h0000, 16'(o_wb_rf_we));
        compare("release nzp we", 16'h0000, 16'(o_wb_nzp_we));

        for (int cyc = 0; cyc < 3000 && !done; cyc++) begin
            @(negedge gwe);
            if (o_dmem_we) begin
                if (st_addr.size() == 0) begin
                    $display("Store to %h seen with no store left in the model", o_dmem_addr);
                    others++;
                end else begin
                    compare("store addr", st_addr.pop_front(), o_dmem_addr);
                    compare("store data", st_data.pop_front(), o_dmem_wdata);
                end
                tb_dmem[o_dmem_addr] = o_dmem_wdata;
            end
            if (o_wb_stall != lc4_pipe_pkg::stall_none) begin
                nbub++;
                bub_or = bub_or | o_wb_stall;
            end else begin
                check_retire();
            end
            drive_memories();
        end
        if (!done) begin
            $display("Timed out with %0d instructions still to retire", exp_trace.size());
            others++;
        end
        if (st_addr.size() != 0) begin
            $display("%0d expected stores never reached data memory", st_addr.size());
            others++;
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
source/lc4_isa_pkg.sv
source/lc4_pipe_pkg.sv
source/lc4_ctrl_if.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_alu.sv
source/lc4_hazard_unit.sv
source/lc4_core.sv
dv/lc4_tb_clock.sv
dv/lc4_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lc4 core testbench with verilator, judge the log
verilator --binary --timing -f build.f --top-module lc4_core_tb -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vlc4_core_tb > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }
